// ==== include/rv_consts.svh ====
// ==============================
// Core constants: reset PC, register count
// and the ALU result select codes
// ==============================

`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// PC of the first accepted word
`define RV_RESET_PC 32'h0000_0000

// Integer registers, x0 included
`define RV_NUM_REGS 32

// ALU result select, 3 bits
`define RV_ALU_ADDER 3'd0
`define RV_ALU_COMP  3'd1
`define RV_ALU_XOR   3'd2
`define RV_ALU_OR    3'd3
`define RV_ALU_AND   3'd4
`define RV_ALU_SHIFT 3'd5

`endif

// ==== logic/rv_types_pkg.sv ====
// ==============================
// Core types: opcode and ALU select enums,
// stage payload structs
// ==============================

`include "rv_consts.svh"

package rv_types_pkg;

    // Opcode bits [6:2], subset only
    typedef enum logic [4:0] {
        INSTR_LUI   = 5'b01101,
        INSTR_AUIPC = 5'b00101,
        INSTR_OPIMM = 5'b00100,
        INSTR_OP    = 5'b01100
    } rv_opcode_e;

    // Which unit drives the result
    typedef enum logic [2:0] {
        ALU_ADDER = `RV_ALU_ADDER,
        ALU_COMP  = `RV_ALU_COMP,
        ALU_XOR   = `RV_ALU_XOR,
        ALU_OR    = `RV_ALU_OR,
        ALU_AND   = `RV_ALU_AND,
        ALU_SHIFT = `RV_ALU_SHIFT
    } alu_sel_e;

    // ==============================
    // Stage payloads

    typedef struct packed {
        logic [31:0] ir;
        logic [31:0] pc;
    } pipe_ifid_t;

    typedef struct packed {
        logic [31:0] op1;       // ALU operand A
        logic [31:0] op2;       // ALU operand B
        logic [31:0] op3;       // Secondary adder operands
        logic [31:0] op4;
        logic        cin;       // Subtract
        logic        rev;       // Left shift via bit reversal
        logic        uns;       // Unsigned compare / zero fill
        logic        eq;        // Equality compare
        logic        inv;       // Invert compare
        logic        align;     // Clear adder LSB
        alu_sel_e    sel;
        logic [4:0]  rd;
        logic        rd_write;
        logic        illegal;
        logic [31:0] pc;
    } pipe_idex_t;

    typedef struct packed {
        logic [4:0]  rd;
        logic        rd_write;
        logic [31:0] data;
        logic        illegal;
        logic [31:0] pc;
    } pipe_exwb_t;

    // Writeback to register file
    typedef struct packed {
        logic        en;
        logic [4:0]  sel;
        logic [31:0] data;
    } regwr_t;

endpackage

// ==== logic/fetch_unit.sv ====
// ==============================
// Fetch: PC counter and IF/ID register
// ==============================

`timescale 1ns/1ps

`include "rv_consts.svh"

module fetch_unit (
    input  logic                    clk,
    input  logic                    rstz,
    // Instruction words from outside
    input  logic [31:0]             instr,
    input  logic                    instr_vld,
    output logic                    instr_rdy,
    // IF/ID
    output rv_types_pkg::pipe_ifid_t fetch,
    output logic                    fetch_vld,
    input  logic                    fetch_rdy
);

logic [31:0] pc;        // PC of next accepted word
logic        accept;

assign instr_rdy = ~fetch_vld | fetch_rdy;     // Empty or draining
assign accept    = instr_vld & instr_rdy;

// Control and PC
always_ff @(posedge clk or negedge rstz) begin
    if (~rstz) begin
        fetch_vld <= 1'b0;
        pc        <= `RV_RESET_PC;
    end else begin
        if (instr_rdy) fetch_vld <= instr_vld;
        if (accept) pc <= pc + 32'd4;           // Word-sized step
    end
end

// Payload, word tagged with its PC
always_ff @(posedge clk) begin
    if (accept) begin
        fetch.ir <= instr;
        fetch.pc <= pc;
    end
end

endmodule

// ==== logic/pipe_stage.sv ====
// ==============================
// One-entry valid/ready pipeline register
// ==============================

`timescale 1ns/1ps

module pipe_stage #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rstz,
    // Upstream
    input  payload_t in_data,
    input  logic     in_vld,
    output logic     in_rdy,
    // Downstream
    output payload_t out_data,
    output logic     out_vld,
    input  logic     out_rdy
);

// Takes a new entry when empty or when the held one leaves
assign in_rdy = ~out_vld | out_rdy;

always_ff @(posedge clk or negedge rstz) begin
    if (~rstz) begin
        out_vld <= 1'b0;
    end else if (in_rdy) begin
        out_vld <= in_vld;      // Bubble when nothing arrives
    end
end

// Held while stalled
always_ff @(posedge clk) begin
    if (in_vld && in_rdy) begin
        out_data <= in_data;
    end
end

endmodule

// ==== logic/instr_decode.sv ====
// ==============================
// Decode: register file, immediate, ALU controls,
// operand select and pending-write scoreboard
// ==============================

`timescale 1ns/1ps

`include "rv_consts.svh"

module instr_decode (
    input  logic                     clk,
    input  logic                     rstz,
    // IF/ID
    input  rv_types_pkg::pipe_ifid_t fetch,
    input  logic                     fetch_vld,
    output logic                     fetch_rdy,
    // ID/EX
    output rv_types_pkg::pipe_idex_t decode,
    output logic                     decode_vld,
    input  logic                     decode_rdy,
    // Writeback
    input  rv_types_pkg::regwr_t     regwr
);

logic [31:0] ir;
logic [4:0]  opc;
logic [4:0]  rs1, rs2, rd;
logic [2:0]  funct3;
logic [6:0]  funct7;
logic        illegal_opcode;
logic        instr_valid;
logic        rd_write;

logic        rs1_en, rs2_en;
logic [31:0] rs1_ram, rs2_ram;      // Negedge read data
logic [31:0] rs1_val, rs2_val;      // After forwarding

logic        format_i, format_u;
logic        sign;
logic        imm_a;
logic [3:0]  imm_b;
logic [5:0]  imm_c;
logic        imm_d;
logic [7:0]  imm_e;
logic [11:0] imm_f;
logic [31:0] immediate;

logic cin, rev, uns;
rv_types_pkg::alu_sel_e sel;
logic is_op, f7_zero, f7_alt;

logic [`RV_NUM_REGS-1:0] pending;
logic stall, accept;

// ==============================
// Instruction fields

assign ir     = fetch.ir;
assign opc    = ir[6:2];
assign rs1    = ir[19:15];
assign rs2    = ir[24:20];
assign rd     = ir[11:7];
assign funct3 = ir[14:12];
assign funct7 = ir[31:25];

assign illegal_opcode = ir[1:0] != 2'b11;

assign rs1_en = opc == rv_types_pkg::INSTR_OPIMM || opc == rv_types_pkg::INSTR_OP;
assign rs2_en = opc == rv_types_pkg::INSTR_OP;

// Illegal words never write
assign rd_write = instr_valid & ~illegal_opcode & (rd != 5'd0);

// ==============================
// Register file, one copy per read port

logic [31:0] regs_a [`RV_NUM_REGS];
logic [31:0] regs_b [`RV_NUM_REGS];

// Read on the falling edge, ready for the next rising edge
always_ff @(negedge clk) begin
    rs1_ram <= regs_a[rs1];
    rs2_ram <= regs_b[rs2];
end

always_ff @(posedge clk) begin
    if (regwr.en) begin
        regs_a[regwr.sel] <= regwr.data;
        regs_b[regwr.sel] <= regwr.data;
    end
end

// Same-cycle write wins; x0 reads zero
always_comb begin
    if (rs1 == 5'd0) rs1_val = '0;
    else if (regwr.en && regwr.sel == rs1) rs1_val = regwr.data;
    else rs1_val = rs1_ram;

    if (rs2 == 5'd0) rs2_val = '0;
    else if (regwr.en && regwr.sel == rs2) rs2_val = regwr.data;
    else rs2_val = rs2_ram;
end

// ==============================
// Immediate, I and U formats

assign format_i = opc == rv_types_pkg::INSTR_OPIMM;
assign format_u = opc == rv_types_pkg::INSTR_LUI || opc == rv_types_pkg::INSTR_AUIPC;
assign sign     = ir[31];

assign imm_a = format_i ? ir[20] : 1'b0;                // [0]
assign imm_b = format_u ? 4'd0 : ir[24:21];             // [4:1]
assign imm_c = format_u ? 6'd0 : ir[30:25];             // [10:5]
assign imm_d = format_u ? 1'b0 : sign;                  // [11]
assign imm_e = format_u ? ir[19:12] : {8{sign}};        // [19:12]
assign imm_f = format_u ? ir[31:20] : {12{sign}};       // [31:20]

assign immediate = {imm_f, imm_e, imm_d, imm_c, imm_b, imm_a};

// ==============================
// ALU controls

assign is_op   = opc == rv_types_pkg::INSTR_OP;
assign f7_zero = funct7 == 7'd0;
assign f7_alt  = funct7 == 7'd32;

always_comb begin
    cin         = 1'b0;         // Default is a plain add
    rev         = 1'b0;
    uns         = 1'b0;
    sel         = rv_types_pkg::ALU_ADDER;
    instr_valid = 1'b0;

    case (opc)
        rv_types_pkg::INSTR_LUI,
        rv_types_pkg::INSTR_AUIPC: instr_valid = 1'b1;

        // Shared by immediate and register forms; funct7 only binds OP and shifts
        rv_types_pkg::INSTR_OPIMM,
        rv_types_pkg::INSTR_OP: begin
            case (funct3)
                3'b000: begin                               // ADD/SUB/ADDI
                    cin         = is_op & f7_alt;
                    instr_valid = ~is_op | f7_zero | f7_alt;
                end
                3'b001: begin                               // SLL
                    rev         = 1'b1;
                    uns         = 1'b1;
                    sel         = rv_types_pkg::ALU_SHIFT;
                    instr_valid = f7_zero;
                end
                3'b010: begin                               // SLT
                    cin         = 1'b1;
                    sel         = rv_types_pkg::ALU_COMP;
                    instr_valid = ~is_op | f7_zero;
                end
                3'b011: begin                               // SLTU
                    cin         = 1'b1;
                    uns         = 1'b1;
                    sel         = rv_types_pkg::ALU_COMP;
                    instr_valid = ~is_op | f7_zero;
                end
                3'b100: begin
                    sel         = rv_types_pkg::ALU_XOR;
                    instr_valid = ~is_op | f7_zero;
                end
                3'b101: begin                               // SRL/SRA
                    uns         = f7_zero;
                    sel         = rv_types_pkg::ALU_SHIFT;
                    instr_valid = f7_zero | f7_alt;
                end
                3'b110: begin
                    sel         = rv_types_pkg::ALU_OR;
                    instr_valid = ~is_op | f7_zero;
                end
                default: begin                              // 3'b111, AND
                    sel         = rv_types_pkg::ALU_AND;
                    instr_valid = ~is_op | f7_zero;
                end
            endcase
        end

        default: instr_valid = 1'b0;    // Loads, stores, branches, system
    endcase
end

// ==============================
// Scoreboard

// Stall on a pending source, or a pending rd so one bit covers one writer;
// a clear in this same cycle lets the word through on the forward path
always_comb begin
    stall = 1'b0;
    if (rs1_en && pending[rs1] && !(regwr.en && regwr.sel == rs1)) stall = 1'b1;
    if (rs2_en && pending[rs2] && !(regwr.en && regwr.sel == rs2)) stall = 1'b1;
    if (rd_write && pending[rd] && !(regwr.en && regwr.sel == rd)) stall = 1'b1;
end

assign fetch_rdy = (~decode_vld | decode_rdy) & ~stall;
assign accept    = fetch_vld & fetch_rdy;

always_ff @(posedge clk or negedge rstz) begin
    if (~rstz) begin
        pending <= '0;
    end else begin
        if (regwr.en) pending[regwr.sel] <= 1'b0;
        if (accept && rd_write) pending[rd] <= 1'b1;    // New writer wins
    end
end

// ==============================
// ID/EX register

always_ff @(posedge clk or negedge rstz) begin
    if (~rstz) begin
        decode_vld <= 1'b0;
    end else if (accept) begin
        decode_vld <= 1'b1;
    end else if (decode_rdy) begin
        decode_vld <= 1'b0;
    end
end

always_ff @(posedge clk) begin
    if (accept) begin
        decode.cin      <= cin;
        decode.rev      <= rev;
        decode.uns      <= uns;
        decode.eq       <= 1'b0;    // Branch compares only
        decode.inv      <= 1'b0;
        decode.align    <= 1'b0;
        decode.sel      <= sel;
        decode.rd       <= rd_write ? rd : 5'd0;
        decode.rd_write <= rd_write;
        decode.illegal  <= ~instr_valid | illegal_opcode;
        decode.pc       <= fetch.pc;
        decode.op3      <= fetch.pc;
        decode.op4      <= '0;

        case (opc)
            rv_types_pkg::INSTR_LUI: begin
                decode.op1 <= '0;
                decode.op2 <= immediate;
            end
            rv_types_pkg::INSTR_AUIPC: begin
                decode.op1 <= fetch.pc;
                decode.op2 <= immediate;
            end
            rv_types_pkg::INSTR_OPIMM: begin
                decode.op1 <= rs1_val;
                decode.op2 <= immediate;
            end
            default: begin      // OP, illegal words just carry the reads
                decode.op1 <= rs1_val;
                decode.op2 <= rs2_val;
            end
        endcase
    end
end

endmodule

// ==== logic/int_alu.sv ====
// ==============================
// Integer ALU of the execute stage and
// the writeback record it builds
// ==============================

`timescale 1ns/1ps

module int_alu (
    // ID/EX
    input  rv_types_pkg::pipe_idex_t decode,
    input  logic                     decode_vld,
    output logic                     decode_rdy,
    // EX/WB
    output rv_types_pkg::pipe_exwb_t exwb,
    output logic                     exwb_vld,
    input  logic                     exwb_rdy
);

logic [31:0] op1, op2;
logic [31:0] addend;
logic [31:0] sum;
logic [31:0] adder_out;
logic        lt, equal, comp;
logic [31:0] shift_in, shift_out;
logic [32:0] shift_ext;
logic        fill;
logic [31:0] result;

assign op1 = decode.op1;
assign op2 = decode.op2;

// Pure combinational stage
assign exwb_vld   = decode_vld;
assign decode_rdy = exwb_rdy;

// ==============================
// Adder and compare

assign addend    = decode.cin ? ~op2 : op2;
assign sum       = op1 + addend + {31'd0, decode.cin};
assign adder_out = decode.align ? {sum[31:1], 1'b0} : sum;

// Sign of the difference decides unless the operand signs differ
always_comb begin
    if (op1[31] == op2[31]) lt = sum[31];
    else if (decode.uns) lt = op2[31];
    else lt = op1[31];
end

assign equal = ~|sum & decode.cin;                  // Zero difference on a subtract
assign comp  = (decode.eq ? equal : lt) ^ decode.inv;

// ==============================
// Right shifter with bit reversal for left shifts

always_comb begin
    for (int i = 0; i < 32; i++) begin
        shift_in[i] = decode.rev ? op1[31-i] : op1[i];
    end
end

assign fill      = ~decode.uns & shift_in[31];      // Arithmetic fill
assign shift_ext = $signed({fill, shift_in}) >>> op2[4:0];

always_comb begin
    for (int i = 0; i < 32; i++) begin
        shift_out[i] = decode.rev ? shift_ext[31-i] : shift_ext[i];
    end
end

// ==============================
// Result select

always_comb begin
    case (decode.sel)
        rv_types_pkg::ALU_COMP:  result = {31'd0, comp};
        rv_types_pkg::ALU_XOR:   result = op1 ^ op2;
        rv_types_pkg::ALU_OR:    result = op1 | op2;
        rv_types_pkg::ALU_AND:   result = op1 & op2;
        rv_types_pkg::ALU_SHIFT: result = shift_out;
        default:                 result = adder_out;
    endcase
end

// Writeback record
always_comb begin
    exwb.rd       = decode.rd;
    exwb.rd_write = decode.rd_write;
    exwb.data     = result;
    exwb.illegal  = decode.illegal;
    exwb.pc       = decode.pc;
end

endmodule

// ==== logic/core_top.sv ====
// ==============================
// Core top: fetch, decode, execute,
// writeback register
// ==============================

`timescale 1ns/1ps

module core_top (
    input  logic                     clk,
    input  logic                     rstz,
    input  logic [31:0]              instr,
    input  logic                     instr_vld,
    output logic                     instr_rdy,
    output rv_types_pkg::pipe_exwb_t retire,
    output logic                     retire_vld
);

rv_types_pkg::pipe_ifid_t fetch;
logic                     fetch_vld, fetch_rdy;
rv_types_pkg::pipe_idex_t decode;
logic                     decode_vld, decode_rdy;
rv_types_pkg::pipe_exwb_t exwb;
logic                     exwb_vld, exwb_rdy;
rv_types_pkg::regwr_t     regwr;

fetch_unit fetch_unit_inst (
    .clk       (clk),
    .rstz      (rstz),
    .instr     (instr),
    .instr_vld (instr_vld),
    .instr_rdy (instr_rdy),
    .fetch     (fetch),
    .fetch_vld (fetch_vld),
    .fetch_rdy (fetch_rdy)
);

instr_decode instr_decode_inst (
    .clk        (clk),
    .rstz       (rstz),
    .fetch      (fetch),
    .fetch_vld  (fetch_vld),
    .fetch_rdy  (fetch_rdy),
    .decode     (decode),
    .decode_vld (decode_vld),
    .decode_rdy (decode_rdy),
    .regwr      (regwr)
);

int_alu int_alu_inst (
    .decode     (decode),
    .decode_vld (decode_vld),
    .decode_rdy (decode_rdy),
    .exwb       (exwb),
    .exwb_vld   (exwb_vld),
    .exwb_rdy   (exwb_rdy)
);

// Writeback register, retire never back-pressures
pipe_stage #(
    .payload_t (rv_types_pkg::pipe_exwb_t)
) wb_stage_inst (
    .clk      (clk),
    .rstz     (rstz),
    .in_data  (exwb),
    .in_vld   (exwb_vld),
    .in_rdy   (exwb_rdy),
    .out_data (retire),
    .out_vld  (retire_vld),
    .out_rdy  (1'b1)
);

// Register write back into decode
always_comb begin
    regwr.en   = retire_vld & retire.rd_write;
    regwr.sel  = retire.rd;
    regwr.data = retire.data;
end

endmodule

// ==== bench/core_tb.sv ====
// ==============================
// Testbench for core_top: clock, reset, reference model,
// retire monitor, directed tests and watchdog
// ==============================

`timescale 1ns/1ps

`include "rv_consts.svh"

module core_tb;

localparam int CLK_PERIOD      = 40;
localparam int RST_CYCLES      = 3;
localparam int LATENCY         = 3;     // Accept to retire, no hazard
localparam int NUM_WORDS       = 140;   // Words issued over all tests
localparam int WATCHDOG_CYCLES = NUM_WORDS * 10 + 200;

localparam logic [6:0] OPC_LUI   = 7'b0110111;
localparam logic [6:0] OPC_AUIPC = 7'b0010111;
localparam logic [6:0] OPC_OPIMM = 7'b0010011;
localparam logic [6:0] OPC_OP    = 7'b0110011;
localparam logic [6:0] OPC_STORE = 7'b0100011;

// Expected retire beat, queued at acceptance
typedef struct packed {
    rv_types_pkg::pipe_exwb_t rec;
    logic                     chk_data;    // Off for illegal words
    logic                     chk_lat;     // Hazard-free word, fixed latency
    logic [31:0]              acc_cnt;
} expect_t;

logic                     clk;
logic                     rstz;
logic [31:0]              instr;
logic                     instr_vld;
logic                     instr_rdy;
rv_types_pkg::pipe_exwb_t retire;
logic                     retire_vld;

logic [31:0] model_regs [`RV_NUM_REGS];
logic [31:0] model_pc;
logic [31:0] rng;
logic [31:0] cycle_cnt;
expect_t     exp_q [$];
int          errors;
int          checks;
int          tests_run;

core_top core_top_inst (
    .clk        (clk),
    .rstz       (rstz),
    .instr      (instr),
    .instr_vld  (instr_vld),
    .instr_rdy  (instr_rdy),
    .retire     (retire),
    .retire_vld (retire_vld)
);

initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
end

// Rising edges since reset
always @(posedge clk or negedge rstz) begin
    if (!rstz) cycle_cnt <= '0;
    else cycle_cnt <= cycle_cnt + 32'd1;
end

// ==============================
// Helpers

function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
endfunction

function automatic logic [31:0] u_type(input logic [6:0] opc, input logic [4:0] rd,
                                       input logic [19:0] imm);
    return {imm, rd, opc};
endfunction

function automatic logic [31:0] i_type(input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [4:0] rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, OPC_OPIMM};
endfunction

function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

// RV32I integer result by funct3; alt picks SUB / SRA
function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return {31'd0, $signed(a) < $signed(b)};
        3'd3:    return {31'd0, a < b};
        3'd4:    return a ^ b;
        3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

function automatic void mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, got);
    errors++;
endfunction

// ==============================
// Reference model, program order

task automatic predict(input logic [31:0] w, input logic chk_lat, input logic [31:0] acc);
    expect_t     e;
    logic [4:0]  rd;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [31:0] a;
    logic [31:0] imm;
    logic [31:0] res;
    logic        legal;
    logic        is_op;
    logic        wr;
    rd    = w[11:7];
    f3    = w[14:12];
    f7    = w[31:25];
    a     = model_regs[w[19:15]];
    imm   = {{20{w[31]}}, w[31:20]};      // I-format, sign extended
    is_op = w[6:0] == OPC_OP;
    legal = 1'b1;
    res   = '0;
    case (w[6:0])
        OPC_LUI:   res = {w[31:12], 12'd0};
        OPC_AUIPC: res = model_pc + {w[31:12], 12'd0};
        OPC_OPIMM, OPC_OP: begin
            if (is_op) legal = f7 == 7'd0 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
            else if (f3 == 3'd1) legal = f7 == 7'd0;                 // SLLI
            else if (f3 == 3'd5) legal = f7 == 7'd0 || f7 == 7'h20;  // SRLI/SRAI
            res = alu_ref(f3, f7[5] & (is_op | (f3 == 3'd5)), a,
                          is_op ? model_regs[w[24:20]] : imm);
        end
        default:   legal = 1'b0;      // Other opcodes, low bits not 11
    endcase
    wr              = legal && rd != 5'd0;
    e.rec.rd        = wr ? rd : 5'd0;
    e.rec.rd_write  = wr;
    e.rec.data      = res;
    e.rec.illegal   = ~legal;
    e.rec.pc        = model_pc;
    e.chk_data      = legal;
    e.chk_lat       = chk_lat;
    e.acc_cnt       = acc;
    exp_q.push_back(e);
    model_pc = model_pc + 32'd4;
    if (wr) model_regs[rd] = res;
endtask

// ==============================
// Retire monitor

always @(negedge clk) begin : retire_monitor
    expect_t e;
    if (rstz && retire_vld) begin
        assert (exp_q.size() != 0) else begin
            $display("Retire at %0t with no word outstanding", $time);
            errors++;
        end
        if (exp_q.size() != 0) begin
            e = exp_q.pop_front();
            checks++;
            assert (retire.pc === e.rec.pc) else mismatch("retire.pc", e.rec.pc, retire.pc);
            assert (retire.illegal === e.rec.illegal)
                else mismatch("retire.illegal", 32'(e.rec.illegal), 32'(retire.illegal));
            assert (retire.rd_write === e.rec.rd_write)
                else mismatch("retire.rd_write", 32'(e.rec.rd_write), 32'(retire.rd_write));
            assert (retire.rd === e.rec.rd)
                else mismatch("retire.rd", 32'(e.rec.rd), 32'(retire.rd));
            if (e.chk_data) begin
                assert (retire.data === e.rec.data)
                    else mismatch("retire.data", e.rec.data, retire.data);
            end
            if (e.chk_lat) begin
                assert (cycle_cnt - e.acc_cnt == 32'(LATENCY))
                    else mismatch("latency", 32'(LATENCY), cycle_cnt - e.acc_cnt);
            end
        end
    end
end

// ==============================
// Driver tasks, entered at posedge + 2 ns

task automatic send_word(input logic [31:0] w, input logic chk_lat);
    instr     = w;
    instr_vld = 1'b1;
    @(negedge clk);
    while (!instr_rdy) @(negedge clk);      // rdy is settled by the falling edge
    predict(w, chk_lat, cycle_cnt);
    @(posedge clk);
    #2;
    instr_vld = 1'b0;
endtask

task automatic idle(input int n);
    if (n > 0) begin
        repeat (n) @(posedge clk);
        #2;
    end
endtask

// LUI then ADDI; upper half rounded for the sign-extended low part
task automatic load_reg(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] upper;
    upper = v + 32'h800;
    send_word(u_type(OPC_LUI, rd, upper[31:12]), 1'b0);
    send_word(i_type(3'd0, rd, rd, v[11:0]), 1'b0);
endtask

task automatic drain();
    while (exp_q.size() != 0) @(posedge clk);
    @(posedge clk);
    #2;
endtask

task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) $display("[%0t] %s: ok", $time, name);
    else $display("[%0t] %s: %0d errors", $time, name, errors - errs_before);
endtask

// ==============================
// Directed tests

task automatic test_upper();
    int          e0;
    logic [31:0] r;
    e0 = errors;
    for (int i = 0; i < 6; i++) begin
        r = next_rand();
        send_word(u_type(OPC_LUI, 5'(i + 1), r[19:0]), 1'b0);
        send_word(u_type(OPC_AUIPC, 5'(i + 7), r[31:12]), 1'b0);  // PC relative
    end
    send_word(u_type(OPC_LUI, 5'd0, 20'hfffff), 1'b0);             // x0, no write
    send_word(u_type(OPC_AUIPC, 5'd13, 20'h80000), 1'b0);
    drain();
    report_test("LUI and AUIPC", e0);
endtask

task automatic test_op_imm();
    int          e0;
    logic [31:0] r;
    logic [11:0] imm;
    logic [4:0]  src;
    e0 = errors;
    load_reg(5'd1, next_rand());
    load_reg(5'd2, next_rand() | 32'h8000_0000);   // Negative source
    load_reg(5'd3, 32'hffff_f800);
    for (int k = 0; k < 4; k++) begin
        r   = next_rand();
        src = 5'((k % 3) + 1);
        imm = r[11:0];
        if (k == 1) imm[11] = 1'b1;                 // Negative immediate
        if (k == 3) imm = 12'h800;                  // Most negative
        send_word(i_type(3'd0, 5'd10, src, imm), 1'b0);                // ADDI
        send_word(i_type(3'd2, 5'd11, src, imm), 1'b0);                // SLTI
        send_word(i_type(3'd3, 5'd12, src, imm), 1'b0);                // SLTIU
        send_word(i_type(3'd4, 5'd13, src, imm), 1'b0);                // XORI
        send_word(i_type(3'd6, 5'd14, src, imm), 1'b0);                // ORI
        send_word(i_type(3'd7, 5'd15, src, imm), 1'b0);                // ANDI
        send_word(i_type(3'd1, 5'd16, src, {7'h00, r[16:12]}), 1'b0);  // SLLI
        send_word(i_type(3'd5, 5'd17, src, {7'h00, r[21:17]}), 1'b0);  // SRLI
        send_word(i_type(3'd5, 5'd18, src, {7'h20, r[26:22]}), 1'b0);  // SRAI
    end
    drain();
    report_test("OP-IMM", e0);
endtask

task automatic test_op();
    int         e0;
    logic [4:0] ra [4];
    logic [4:0] rb [4];
    e0 = errors;
    load_reg(5'd4, next_rand());
    load_reg(5'd5, next_rand());
    load_reg(5'd6, 32'h8000_0000);      // Sign boundary values
    load_reg(5'd7, 32'h7fff_ffff);
    load_reg(5'd8, 32'hffff_ffff);
    ra[0] = 5'd4;
    rb[0] = 5'd5;
    ra[1] = 5'd5;
    rb[1] = 5'd5;                       // Equal operands
    ra[2] = 5'd6;
    rb[2] = 5'd7;
    ra[3] = 5'd8;
    rb[3] = 5'd6;
    for (int p = 0; p < 4; p++) begin
        send_word(r_type(7'h00, 3'd0, 5'd20, ra[p], rb[p]), 1'b0);    // ADD
        send_word(r_type(7'h20, 3'd0, 5'd21, ra[p], rb[p]), 1'b0);    // SUB
        send_word(r_type(7'h00, 3'd1, 5'd22, ra[p], rb[p]), 1'b0);    // SLL
        send_word(r_type(7'h00, 3'd2, 5'd23, ra[p], rb[p]), 1'b0);    // SLT
        send_word(r_type(7'h00, 3'd3, 5'd24, ra[p], rb[p]), 1'b0);    // SLTU
        send_word(r_type(7'h00, 3'd4, 5'd25, ra[p], rb[p]), 1'b0);    // XOR
        send_word(r_type(7'h00, 3'd5, 5'd26, ra[p], rb[p]), 1'b0);    // SRL
        send_word(r_type(7'h20, 3'd5, 5'd27, ra[p], rb[p]), 1'b0);    // SRA
        send_word(r_type(7'h00, 3'd6, 5'd28, ra[p], rb[p]), 1'b0);    // OR
        send_word(r_type(7'h00, 3'd7, 5'd29, ra[p], rb[p]), 1'b0);    // AND
    end
    drain();
    report_test("OP", e0);
endtask

task automatic test_raw_chain();
    int          e0;
    logic [31:0] r;
    e0 = errors;
    r = next_rand();
    send_word(i_type(3'd0, 5'd8, 5'd0, r[11:0]), 1'b0);
    for (int i = 0; i < 4; i++) begin
        send_word(i_type(3'd0, 5'd8, 5'd8, r[23:12]), 1'b0);         // Back-to-back on x8
    end
    send_word(r_type(7'h00, 3'd0, 5'd9, 5'd8, 5'd8), 1'b0);
    send_word(r_type(7'h20, 3'd0, 5'd9, 5'd9, 5'd8), 1'b0);          // Back to x8
    send_word(r_type(7'h00, 3'd4, 5'd10, 5'd9, 5'd8), 1'b0);         // Zero
    send_word(r_type(7'h00, 3'd1, 5'd11, 5'd8, 5'd10), 1'b0);
    send_word(i_type(3'd0, 5'd0, 5'd8, 12'h005), 1'b0);              // Dropped x0 write
    send_word(r_type(7'h00, 3'd0, 5'd12, 5'd0, 5'd8), 1'b0);
    send_word(r_type(7'h00, 3'd3, 5'd13, 5'd0, 5'd11), 1'b0);
    drain();
    report_test("Read-after-write chains", e0);
endtask

task automatic test_illegal();
    int e0;
    e0 = errors;
    load_reg(5'd1, next_rand());
    load_reg(5'd2, next_rand());
    send_word(i_type(3'd0, 5'd1, 5'd2, 12'h123) & 32'hffff_fffe, 1'b0);  // Low bits 10
    send_word({7'd0, 5'd2, 5'd1, 3'b010, 5'd4, OPC_STORE}, 1'b0);       // SW
    send_word(r_type(7'h01, 3'd0, 5'd2, 5'd1, 5'd2), 1'b0);             // Bad funct7
    send_word(r_type(7'h00, 3'd0, 5'd3, 5'd1, 5'd0), 1'b0);             // Read back x1
    send_word(r_type(7'h00, 3'd0, 5'd4, 5'd2, 5'd0), 1'b0);
    send_word(u_type(OPC_AUIPC, 5'd5, 20'd0), 1'b0);                    // PC still in step
    drain();
    report_test("Illegal words", e0);
endtask

task automatic test_throughput();
    int          e0;
    logic [31:0] r;
    e0 = errors;
    for (int i = 0; i < 12; i++) begin
        r = next_rand();
        send_word(i_type(3'd0, 5'(i + 1), 5'd0, r[11:0]), 1'b1);     // Distinct rd
        if (r[31]) idle(int'(r[30]) + 1);                             // Input pause
    end
    drain();
    report_test("Throughput and input pauses", e0);
endtask

// ==============================
// Main sequence

initial begin
    rstz      = 1'b0;
    instr     = '0;
    instr_vld = 1'b0;
    errors    = 0;
    checks    = 0;
    tests_run = 0;
    rng       = 32'h3bbca3cf;
    model_pc  = `RV_RESET_PC;
    for (int i = 0; i < `RV_NUM_REGS; i++) model_regs[i] = '0;
    repeat (RST_CYCLES) @(posedge clk);
    #2;
    rstz = 1'b1;
    test_upper();
    test_op_imm();
    test_op();
    test_raw_chain();
    test_illegal();
    test_throughput();
    $display("%0d tests, %0d retired words checked, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
        $display("All tests passed!");
    end else begin
        $display("Test failures found");
    end
    $finish;
end

// Watchdog sized from the word count
initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Retirement stalled, %0d words still outstanding after %0d cycles",
             exp_q.size(), WATCHDOG_CYCLES);
    $display("Test failures found");
    $finish;
end

endmodule

// ==== list.f ====
+incdir+include
logic/rv_types_pkg.sv
logic/fetch_unit.sv
logic/pipe_stage.sv
logic/instr_decode.sv
logic/int_alu.sv
logic/core_top.sv
bench/core_tb.sv

// ==== Makefile ====
# Verilator flow for core_tb: compile, run, clean

TOP = core_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -f list.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q 'All tests passed!'

clean:
	rm -rf obj_dir
